// ==== logic/core_pkg.sv ====
/* Widths, RV32 encodings and the two views of the instruction word
   shared by the integer core; modules take it by wildcard import */
package core_pkg;

    //////////////////////////////
    // Widths
    localparam int XLEN = 32;
    localparam int NUM_REGS = 32;

    typedef logic [4:0] reg_addr_t;

    //////////////////////////////
    // Encodings
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    // Upper function field, SUB/SRA and M extension
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // Lower function field
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    //////////////////////////////
    // Instruction word
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_addr_t rs2;
            reg_addr_t rs1;
            logic [2:0] funct3;
            reg_addr_t rd;
            logic [6:0] opcode;
        } r_type;
        struct packed {
            logic [11:0] imm;
            reg_addr_t rs1;
            logic [2:0] funct3;
            reg_addr_t rd;
            logic [6:0] opcode;
        } i_type;
    } instr_t;

endpackage

// ==== logic/alu_unit.sv ====
/* Single-cycle integer ALU: add/sub, logic, compares and shifts, with the
   result and destination register captured one edge after issue */
`timescale 1ns/1ps

module alu_unit
    import core_pkg::*;
    (
        input logic clk,
        input logic rst,

        input logic alu_issue,
        input alu_op_t alu_op,
        input logic [XLEN-1:0] alu_a,
        input logic [XLEN-1:0] alu_b,
        input reg_addr_t alu_rd,

        output logic alu_done,
        output reg_addr_t alu_done_rd,
        output logic [XLEN-1:0] alu_result
    );

    logic [4:0] shamt;
    logic signed_lt;
    logic unsigned_lt;
    logic [XLEN-1:0] result;

    assign shamt = alu_b[4:0];
    assign signed_lt = $signed(alu_a) < $signed(alu_b);
    assign unsigned_lt = alu_a < alu_b;

    //////////////////////////////
    // Operation select
    always_comb begin
        case (alu_op)
            ALU_SUB: result = alu_a - alu_b;
            ALU_AND: result = alu_a & alu_b;
            ALU_OR: result = alu_a | alu_b;
            ALU_XOR: result = alu_a ^ alu_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, signed_lt};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, unsigned_lt};
            ALU_SLL: result = alu_a << shamt;
            ALU_SRL: result = alu_a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA: result = $unsigned($signed(alu_a) >>> shamt);
            default: result = alu_a + alu_b;
        endcase
    end

    //////////////////////////////
    // Output register
    always_ff @(posedge clk) begin
        if (rst)
            alu_done <= 1'b0;
        else
            alu_done <= alu_issue;
    end

    always_ff @(posedge clk) begin
        if (alu_issue) begin
            alu_done_rd <= alu_rd;
            alu_result <= result;
        end
    end

endmodule

// ==== logic/mul_unit.sv ====
/* Pipelined 32-bit multiplier returning the low product word; the
   product, valid bit and rd ride along MUL_STAGES register stages */
`timescale 1ns/1ps

module mul_unit
    import core_pkg::*;
    #(
        parameter int MUL_STAGES = 3
    )
    (
        input logic clk,
        input logic rst,

        input logic mul_issue,
        input logic [XLEN-1:0] mul_a,
        input logic [XLEN-1:0] mul_b,
        input reg_addr_t mul_rd,

        output logic mul_done,
        output reg_addr_t mul_done_rd,
        output logic [XLEN-1:0] mul_result
    );

    logic [MUL_STAGES-1:0] stage_valid;
    logic [XLEN-1:0] stage_prod [MUL_STAGES];
    reg_addr_t stage_rd [MUL_STAGES];

    //////////////////////////////
    // Valid chain
    always_ff @(posedge clk) begin
        if (rst)
            stage_valid <= '0;
        else
            stage_valid <= (stage_valid << 1) | MUL_STAGES'(mul_issue);
    end

    // Only the low word is kept so operand signs do not matter
    always_ff @(posedge clk) begin
        stage_prod[0] <= mul_a * mul_b;
        stage_rd[0] <= mul_rd;
        for (int i = 1; i < MUL_STAGES; i++) begin
            stage_prod[i] <= stage_prod[i-1];
            stage_rd[i] <= stage_rd[i-1];
        end
    end

    assign mul_done = stage_valid[MUL_STAGES-1];
    assign mul_done_rd = stage_rd[MUL_STAGES-1];
    assign mul_result = stage_prod[MUL_STAGES-1];

    //////////////////////////////
    // Fixed latency
    mul_latency: assert property (@(posedge clk) disable iff (rst)
        mul_issue |-> ##MUL_STAGES mul_done)
        else $error("MUL result missing after %0d cycles", MUL_STAGES);

endmodule

// ==== logic/register_file.sv ====
/* Architectural registers with in-use scoreboard bits; merges unit results
   into writeback and drives the registered commit port */
`timescale 1ns/1ps

module register_file
    import core_pkg::*;
    (
        input logic clk,
        input logic rst,

        input reg_addr_t rs1_addr,
        input reg_addr_t rs2_addr,
        input reg_addr_t rd_addr,
        output logic [XLEN-1:0] rs1_data,
        output logic [XLEN-1:0] rs2_data,
        output logic rs1_busy,
        output logic rs2_busy,
        output logic rd_busy,

        input logic issue_rd_valid,
        input reg_addr_t issue_rd,

        input logic alu_done,
        input reg_addr_t alu_done_rd,
        input logic [XLEN-1:0] alu_result,
        input logic mul_done,
        input reg_addr_t mul_done_rd,
        input logic [XLEN-1:0] mul_result,

        output logic commit_valid,
        output reg_addr_t commit_rd,
        output logic [XLEN-1:0] commit_data
    );

    logic [XLEN-1:0] regs [NUM_REGS];
    logic [NUM_REGS-1:0] inuse;
    logic wb_valid;
    reg_addr_t wb_rd;
    logic [XLEN-1:0] wb_data;

    //////////////////////////////
    // Read side
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign rs1_busy = inuse[rs1_addr];
    assign rs2_busy = inuse[rs2_addr];
    assign rd_busy = inuse[rd_addr];

    //////////////////////////////
    // Writeback select
    assign wb_valid = alu_done || mul_done;
    assign wb_rd = alu_done ? alu_done_rd : mul_done_rd;
    assign wb_data = alu_done ? alu_result : mul_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wb_valid && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Scoreboard, x0 is never marked
    always_ff @(posedge clk) begin
        if (rst) begin
            inuse <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (wb_valid)
                inuse[wb_rd] <= 1'b0;
            if (issue_rd_valid && (issue_rd != '0))
                inuse[issue_rd] <= 1'b1;
            commit_valid <= wb_valid && (wb_rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        commit_rd <= wb_rd;
        commit_data <= wb_data;
    end

    // Slot tracking in decode keeps the units apart
    single_writeback: assert property (@(posedge clk) disable iff (rst)
        !(alu_done && mul_done))
        else $error("ALU and MUL results collided at writeback");

    // Decode stalls on a busy rd
    no_double_claim: assert property (@(posedge clk) disable iff (rst)
        issue_rd_valid |-> !inuse[issue_rd])
        else $error("Destination claimed while already in use");

endmodule

// ==== logic/decode_issue.sv ====
/* Decode and issue stage: checks scoreboard and writeback slot hazards,
   then registers the operands into the ALU or the multiply unit */
`timescale 1ns/1ps

module decode_issue
    import core_pkg::*;
    #(
        parameter int MUL_STAGES = 3
    )
    (
        input logic clk,
        input logic rst,

        input logic instr_valid,
        input instr_t instr,
        output logic instr_ready,

        output reg_addr_t rs1_addr,
        output reg_addr_t rs2_addr,
        input logic [XLEN-1:0] rs1_data,
        input logic [XLEN-1:0] rs2_data,
        input logic rs1_busy,
        input logic rs2_busy,
        input logic rd_busy,

        output logic issue_rd_valid,
        output reg_addr_t issue_rd,

        output logic alu_issue,
        output alu_op_t alu_op,
        output logic [XLEN-1:0] alu_a,
        output logic [XLEN-1:0] alu_b,
        output reg_addr_t alu_rd,

        output logic mul_issue,
        output logic [XLEN-1:0] mul_a,
        output logic [XLEN-1:0] mul_b,
        output reg_addr_t mul_rd
    );

    logic supported;
    logic is_mul;
    logic uses_rs2;
    logic hazard;
    logic slot_conflict;
    logic accept;
    logic alu_accept;
    logic mul_accept;
    alu_op_t dec_op;
    logic [XLEN-1:0] imm_ext;
    logic [XLEN-1:0] operand_b;
    // Bit k set: a MUL was accepted k+1 cycles ago
    logic [MUL_STAGES-2:0] mul_slot;

    if (MUL_STAGES < 2) begin : g_stage_check
        $error("decode_issue needs MUL_STAGES of at least 2");
    end

    function automatic alu_op_t base_op(input logic [2:0] funct3);
        case (funct3)
            F3_SLL: return ALU_SLL;
            F3_SLT: return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR: return ALU_XOR;
            F3_SRL_SRA: return ALU_SRL;
            F3_OR: return ALU_OR;
            F3_AND: return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    //////////////////////////////
    // Decode
    assign rs1_addr = instr.r_type.rs1;
    assign rs2_addr = instr.r_type.rs2;
    assign issue_rd = instr.r_type.rd;
    assign imm_ext = {{(XLEN-12){instr.i_type.imm[11]}}, instr.i_type.imm};

    always_comb begin
        supported = 1'b0;
        is_mul = 1'b0;
        uses_rs2 = 1'b0;
        dec_op = base_op(instr.r_type.funct3);
        case (instr.r_type.opcode)
            OP: begin
                uses_rs2 = 1'b1;
                if (instr.r_type.funct7 == FUNCT7_MULDIV) begin
                    is_mul = 1'b1;
                    supported = (instr.r_type.funct3 == F3_ADD_SUB);
                end else if (instr.r_type.funct7 == '0) begin
                    supported = 1'b1;
                end else if (instr.r_type.funct7 == FUNCT7_ALT) begin
                    supported = (instr.r_type.funct3 == F3_ADD_SUB) ||
                                (instr.r_type.funct3 == F3_SRL_SRA);
                    dec_op = (instr.r_type.funct3 == F3_ADD_SUB) ? ALU_SUB : ALU_SRA;
                end
            end
            OP_IMM: begin
                // Shift immediates keep funct7 in the upper imm bits
                case (instr.i_type.funct3)
                    F3_SLL: supported = (instr.i_type.imm[11:5] == '0);
                    F3_SRL_SRA: begin
                        supported = (instr.i_type.imm[11:5] == '0) ||
                                    (instr.i_type.imm[11:5] == FUNCT7_ALT);
                        if (instr.i_type.imm[11:5] == FUNCT7_ALT)
                            dec_op = ALU_SRA;
                    end
                    default: supported = 1'b1;
                endcase
            end
            default: ;
        endcase
    end

    assign operand_b = uses_rs2 ? rs2_data : imm_ext;

    //////////////////////////////
    // Ready and hazards
    assign hazard = rs1_busy || (uses_rs2 && rs2_busy) || rd_busy;
    // ALU result would land on the same writeback cycle as that MUL
    assign slot_conflict = !is_mul && mul_slot[MUL_STAGES-2];

    // Unsupported words drain immediately
    assign instr_ready = !rst && (!supported || !(hazard || slot_conflict));
    assign accept = instr_valid && instr_ready;
    assign alu_accept = accept && supported && !is_mul;
    assign mul_accept = accept && supported && is_mul;
    assign issue_rd_valid = accept && supported && (issue_rd != '0);

    //////////////////////////////
    // Issue registers
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_issue <= 1'b0;
            mul_issue <= 1'b0;
            mul_slot <= '0;
        end else begin
            alu_issue <= alu_accept;
            mul_issue <= mul_accept;
            mul_slot <= (mul_slot << 1) | (MUL_STAGES-1)'(mul_accept);
        end
    end

    always_ff @(posedge clk) begin
        if (alu_accept) begin
            alu_op <= dec_op;
            alu_a <= rs1_data;
            alu_b <= operand_b;
            alu_rd <= issue_rd;
        end
        if (mul_accept) begin
            mul_a <= rs1_data;
            mul_b <= rs2_data;
            mul_rd <= issue_rd;
        end
    end

    // One unit per accepted instruction
    single_unit_issue: assert property (@(posedge clk) disable iff (rst)
        !(alu_issue && mul_issue))
        else $error("ALU and MUL issued in the same cycle");

endmodule

// ==== logic/int_core.sv ====
/* Integer issue-and-execute core top level: decode/issue, register file,
   ALU and multiply unit; instructions in on valid/ready, results out on commit */
`timescale 1ns/1ps

module int_core
    import core_pkg::*;
    #(
        parameter int MUL_STAGES = 3
    )
    (
        input logic clk,
        input logic rst,

        input logic instr_valid,
        input instr_t instr,
        output logic instr_ready,

        output logic commit_valid,
        output reg_addr_t commit_rd,
        output logic [XLEN-1:0] commit_data
    );

    //////////////////////////////
    // Connecting signals
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic rs1_busy;
    logic rs2_busy;
    logic rd_busy;
    logic issue_rd_valid;
    reg_addr_t issue_rd;

    logic alu_issue;
    alu_op_t alu_op;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    reg_addr_t alu_rd;
    logic alu_done;
    reg_addr_t alu_done_rd;
    logic [XLEN-1:0] alu_result;

    logic mul_issue;
    logic [XLEN-1:0] mul_a;
    logic [XLEN-1:0] mul_b;
    reg_addr_t mul_rd;
    logic mul_done;
    reg_addr_t mul_done_rd;
    logic [XLEN-1:0] mul_result;

    //////////////////////////////
    // Decode/Issue
    decode_issue #(.MUL_STAGES(MUL_STAGES))
    decode_issue_block (
        .clk (clk),
        .rst (rst),
        .instr_valid (instr_valid),
        .instr (instr),
        .instr_ready (instr_ready),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_busy (rs1_busy),
        .rs2_busy (rs2_busy),
        .rd_busy (rd_busy),
        .issue_rd_valid (issue_rd_valid),
        .issue_rd (issue_rd),
        .alu_issue (alu_issue),
        .alu_op (alu_op),
        .alu_a (alu_a),
        .alu_b (alu_b),
        .alu_rd (alu_rd),
        .mul_issue (mul_issue),
        .mul_a (mul_a),
        .mul_b (mul_b),
        .mul_rd (mul_rd)
    );

    //////////////////////////////
    // Register file, rd lookup uses the decoded rd
    register_file register_file_block (
        .clk (clk),
        .rst (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr (issue_rd),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_busy (rs1_busy),
        .rs2_busy (rs2_busy),
        .rd_busy (rd_busy),
        .issue_rd_valid (issue_rd_valid),
        .issue_rd (issue_rd),
        .alu_done (alu_done),
        .alu_done_rd (alu_done_rd),
        .alu_result (alu_result),
        .mul_done (mul_done),
        .mul_done_rd (mul_done_rd),
        .mul_result (mul_result),
        .commit_valid (commit_valid),
        .commit_rd (commit_rd),
        .commit_data (commit_data)
    );

    //////////////////////////////
    // Execution units
    alu_unit alu_unit_block (
        .clk (clk),
        .rst (rst),
        .alu_issue (alu_issue),
        .alu_op (alu_op),
        .alu_a (alu_a),
        .alu_b (alu_b),
        .alu_rd (alu_rd),
        .alu_done (alu_done),
        .alu_done_rd (alu_done_rd),
        .alu_result (alu_result)
    );

    mul_unit #(.MUL_STAGES(MUL_STAGES))
    mul_unit_block (
        .clk (clk),
        .rst (rst),
        .mul_issue (mul_issue),
        .mul_a (mul_a),
        .mul_b (mul_b),
        .mul_rd (mul_rd),
        .mul_done (mul_done),
        .mul_done_rd (mul_done_rd),
        .mul_result (mul_result)
    );

endmodule

// ==== tb/tb_clock.sv ====
/* Clock and synchronous reset source for the core testbench */
`timescale 1ns/1ps

module tb_clock
    #(
        parameter int PERIOD_NS = 4,
        parameter int RESET_CYCLES = 5
    )
    (
        output logic clk,
        output logic rst
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// ==== tb/core_checker.sv ====
/* Reference model of the integer core for the testbench; mirrors accepted
   instructions and matches each commit by destination register */
`timescale 1ns/1ps

module core_checker
    import core_pkg::*;
    #(
        parameter int MUL_STAGES = 3
    )
    (
        input logic clk,
        input logic rst,
        input logic instr_valid,
        input instr_t instr,
        input logic instr_ready,
        input logic commit_valid,
        input reg_addr_t commit_rd,
        input logic [XLEN-1:0] commit_data,
        input logic end_of_test,
        output int value_errors,
        output int latency_errors,
        output int count_errors,
        output int reset_errors,
        output int pending_count
    );

    logic [XLEN-1:0] model_regs [NUM_REGS];
    logic [NUM_REGS-1:0] exp_valid;
    logic [XLEN-1:0] exp_data [NUM_REGS];
    int exp_cycle [NUM_REGS];
    int cycle;
    logic seen_reset_edge;
    logic report_done;

    // Executes RV32I register and immediate ops plus MUL and returns 1 if supported
    function automatic logic model_exec(
        input instr_t w,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] rb,
        output logic [XLEN-1:0] res,
        output logic is_mul
    );
        logic [XLEN-1:0] b;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [63:0] prod;
        logic is_op;
        logic ok;
        ok = 1'b1;
        is_mul = 1'b0;
        res = '0;
        f3 = w.r_type.funct3;
        is_op = (w.r_type.opcode == OP);
        b = is_op ? rb : {{(XLEN-12){w.i_type.imm[11]}}, w.i_type.imm};
        f7 = w.r_type.funct7;
        // Immediates carry a function code only for shifts
        if (!is_op)
            f7 = (f3 == F3_SLL || f3 == F3_SRL_SRA) ? w.i_type.imm[11:5] : 7'h00;
        if (!is_op && w.r_type.opcode != OP_IMM) begin
            ok = 1'b0;
        end else if (is_op && f7 == FUNCT7_MULDIV) begin
            is_mul = 1'b1;
            ok = (f3 == F3_ADD_SUB);
            prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
            res = prod[31:0];
        end else if (f7 == FUNCT7_ALT) begin
            ok = (f3 == F3_SRL_SRA) || (is_op && f3 == F3_ADD_SUB);
            if (f3 == F3_SRL_SRA)
                res = $signed(a) >>> b[4:0];
            else
                res = a - b;
        end else if (f7 != 7'h00) begin
            ok = 1'b0;
        end else begin
            case (f3)
                F3_ADD_SUB: res = a + b;
                F3_SLL: res = a << b[4:0];
                F3_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                F3_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                F3_XOR: res = a ^ b;
                F3_SRL_SRA: res = a >> b[4:0];
                F3_OR: res = a | b;
                default: res = a & b;
            endcase
        end
        return ok;
    endfunction

    initial begin
        for (int i = 0; i < NUM_REGS; i++)
            model_regs[i] = '0;
        exp_valid = '0;
        cycle = 0;
        seen_reset_edge = 1'b0;
        report_done = 1'b0;
        value_errors = 0;
        latency_errors = 0;
        count_errors = 0;
        reset_errors = 0;
        pending_count = 0;
    end

    //////////////////////////////
    // Sampling at the rising edge
    always @(posedge clk) begin
        logic [XLEN-1:0] res;
        logic mul_op;
        reg_addr_t rd;
        if (rst) begin
            // Registered outputs settle after the first reset edge
            if (seen_reset_edge && (commit_valid !== 1'b0 || instr_ready !== 1'b0)) begin
                $display("Reset held but commit_valid=%b instr_ready=%b",
                         commit_valid, instr_ready);
                reset_errors++;
            end
            seen_reset_edge = 1'b1;
        end else begin
            cycle++;
            // Commits go first since a freed register can be claimed at the same edge
            if (commit_valid === 1'b1) begin
                if (!exp_valid[commit_rd]) begin
                    $display("Commit to x%0d with no result pending", commit_rd);
                    count_errors++;
                end else begin
                    if (commit_data !== exp_data[commit_rd]) begin
                        $display("FAILED: commit_data x%0d = %h, expected %h",
                                 commit_rd, commit_data, exp_data[commit_rd]);
                        value_errors++;
                    end
                    if (cycle != exp_cycle[commit_rd]) begin
                        $display("Commit to x%0d came at cycle %0d instead of cycle %0d",
                                 commit_rd, cycle, exp_cycle[commit_rd]);
                        latency_errors++;
                    end
                    exp_valid[commit_rd] = 1'b0;
                    pending_count--;
                end
            end else if (commit_valid !== 1'b0) begin
                $display("commit_valid is unknown after reset");
                count_errors++;
            end

            if (instr_valid === 1'b1 && instr_ready === 1'b1) begin
                rd = instr.r_type.rd;
                if (model_exec(instr, model_regs[instr.r_type.rs1],
                               model_regs[instr.r_type.rs2], res, mul_op) && rd != '0) begin
                    if (exp_valid[rd]) begin
                        $display("Instruction accepted while x%0d still had a result pending", rd);
                        count_errors++;
                    end else begin
                        pending_count++;
                    end
                    model_regs[rd] = res;
                    exp_valid[rd] = 1'b1;
                    exp_data[rd] = res;
                    // Commit registered 2 edges (ALU) or MUL_STAGES+1 edges later
                    exp_cycle[rd] = cycle + (mul_op ? MUL_STAGES + 2 : 3);
                end
            end

            if (end_of_test && !report_done) begin
                report_done = 1'b1;
                for (int r = 1; r < NUM_REGS; r++) begin
                    if (exp_valid[r]) begin
                        $display("No commit arrived for x%0d by the end of the run", r);
                        count_errors++;
                    end
                end
            end
        end
    end

endmodule

// ==== tb/core_tb.sv ====
/* Testbench top for the integer core, driving an LCG instruction stream on the
   valid/ready port while core_checker compares commits against a model */
`timescale 1ns/1ps

module core_tb
    import core_pkg::*;
    ();

    localparam int MUL_STAGES = 3;
    localparam int NUM_INSTR = 2000;
    localparam int CLK_PERIOD = 4;
    localparam logic [31:0] SEED = 32'h1b1d_5235;

    logic clk;
    logic rst;
    logic instr_valid;
    instr_t instr;
    logic instr_ready;
    logic commit_valid;
    reg_addr_t commit_rd;
    logic [XLEN-1:0] commit_data;
    logic end_of_test;
    int value_errors;
    int latency_errors;
    int count_errors;
    int reset_errors;
    int pending_count;
    logic [31:0] rng_state;

    tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(5)) clock_gen (
        .clk (clk),
        .rst (rst)
    );

    int_core #(.MUL_STAGES(MUL_STAGES)) uut (
        .clk (clk),
        .rst (rst),
        .instr_valid (instr_valid),
        .instr (instr),
        .instr_ready (instr_ready),
        .commit_valid (commit_valid),
        .commit_rd (commit_rd),
        .commit_data (commit_data)
    );

    core_checker #(.MUL_STAGES(MUL_STAGES)) check (
        .clk (clk),
        .rst (rst),
        .instr_valid (instr_valid),
        .instr (instr),
        .instr_ready (instr_ready),
        .commit_valid (commit_valid),
        .commit_rd (commit_rd),
        .commit_data (commit_data),
        .end_of_test (end_of_test),
        .value_errors (value_errors),
        .latency_errors (latency_errors),
        .count_errors (count_errors),
        .reset_errors (reset_errors),
        .pending_count (pending_count)
    );

    //////////////////////////////
    // Random source
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Mostly x0..x3 so that neighbours collide on the scoreboard
    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = lcg_next();
        if (r[31:29] == 3'd0)
            return r[20:16];
        return {3'b000, r[17:16]};
    endfunction

    function automatic instr_t make_instr();
        logic [31:0] r;
        instr_t w;
        r = lcg_next();
        w.r_type.funct3 = r[22:20];
        w.r_type.rd = pick_reg();
        w.r_type.rs1 = pick_reg();
        if (r[31:28] < 4'd6) begin
            w.r_type.opcode = OP;
            w.r_type.rs2 = pick_reg();
            w.r_type.funct7 = 7'h00;
            if ((r[22:20] == F3_ADD_SUB || r[22:20] == F3_SRL_SRA) && r[19])
                w.r_type.funct7 = FUNCT7_ALT;
        end else if (r[31:28] < 4'd11) begin
            w.i_type.opcode = OP_IMM;
            w.i_type.imm = r[11:0];
            if (r[22:20] == F3_SLL)
                w.i_type.imm[11:5] = 7'h00;
            else if (r[22:20] == F3_SRL_SRA)
                w.i_type.imm[11:5] = r[19] ? FUNCT7_ALT : 7'h00;
        end else if (r[31:28] < 4'd15) begin
            w.r_type.opcode = OP;
            w.r_type.rs2 = pick_reg();
            w.r_type.funct3 = F3_ADD_SUB;
            w.r_type.funct7 = FUNCT7_MULDIV;
        end else if (r[18]) begin
            w = lcg_next();
        end else begin
            // M extension forms other than MUL
            w.r_type.opcode = OP;
            w.r_type.rs2 = pick_reg();
            w.r_type.funct3 = r[22:20] | 3'b001;
            w.r_type.funct7 = FUNCT7_MULDIV;
        end
        return w;
    endfunction

    //////////////////////////////
    // Stimulus
    initial begin
        logic [31:0] gap;
        logic accepted;
        int drain;
        int total;
        rng_state = SEED;
        instr_valid = 1'b0;
        instr = '0;
        end_of_test = 1'b0;
        wait (rst == 1'b0);
        @(negedge clk);
        for (int n = 0; n < NUM_INSTR; n++) begin
            instr = make_instr();
            instr_valid = 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(posedge clk);
                accepted = (instr_ready === 1'b1);
            end
            @(negedge clk);
            // Occasional bubble with a junk word on the bus
            gap = lcg_next();
            if (gap[31:30] == 2'd0) begin
                instr_valid = 1'b0;
                instr = lcg_next();
                repeat (gap[17:16] + 1) @(negedge clk);
            end
        end
        instr_valid = 1'b0;

        drain = 0;
        while (pending_count != 0 && drain < 4 * (MUL_STAGES + 4)) begin
            @(negedge clk);
            drain++;
        end
        // Room for stray commits to show up
        repeat (8) @(negedge clk);
        end_of_test = 1'b1;
        repeat (2) @(negedge clk);

        total = value_errors + latency_errors + count_errors + reset_errors;
        $display("Errors: value %0d, latency %0d, commit count %0d, reset %0d",
                 value_errors, latency_errors, count_errors, reset_errors);
        if (total == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Watchdog allows about 20 cycles per instruction
    initial begin
        #(NUM_INSTR * 20 * CLK_PERIOD);
        $display("Watchdog expired: the run did not finish within %0d cycles",
                 NUM_INSTR * 20);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== sources.f ====
logic/core_pkg.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/register_file.sv
logic/decode_issue.sv
logic/int_core.sv
tb/tb_clock.sv
tb/core_checker.sv
tb/core_tb.sv
